// File: cpu_types_pkg.sv
package cpu_types_pkg;

    // --------------------------------------------------
    // core-wide widths
    // --------------------------------------------------
    parameter int XLEN  = 32;
    parameter int TAG_W = 5;

    // data word and rob tag
    typedef logic [XLEN-1:0]  word_t;
    typedef logic [TAG_W-1:0] rob_id_t;

    // --------------------------------------------------
    // one slot of the common data bus
    // --------------------------------------------------
    typedef struct packed {
        logic    valid;
        rob_id_t tag;
        word_t   data;
    } cdb_t;

endpackage

// File: mdu_pkg.sv
package mdu_pkg;

    // --------------------------------------------------
    // operation codes
    // --------------------------------------------------
    typedef enum logic [1:0] {
        MDU_MUL  = 2'b00,
        MDU_MULH = 2'b01,
        MDU_DIVU = 2'b10,
        MDU_REMU = 2'b11
    } mdu_op_e;

    // source operand, value valid once ready is set
    typedef struct packed {
        logic                   ready;
        cpu_types_pkg::rob_id_t tag;
        cpu_types_pkg::word_t   value;
    } operand_t;

    // --------------------------------------------------
    // payloads
    // --------------------------------------------------
    // operation as it sits in the issue queue
    typedef struct packed {
        mdu_op_e                op;
        cpu_types_pkg::rob_id_t dst;
        operand_t [1:0]         src;
    } iq_req_t;

    // operation handed from issue to the unit
    typedef struct packed {
        mdu_op_e                    op;
        cpu_types_pkg::rob_id_t     dst;
        cpu_types_pkg::word_t [1:0] src;
    } mdu_req_t;

    // finished result toward the output FIFO
    typedef struct packed {
        cpu_types_pkg::rob_id_t tag;
        cpu_types_pkg::word_t   data;
    } mdu_res_t;

endpackage

// File: iq_ptr_ctrl.sv
`timescale 1ns/1ps

module iq_ptr_ctrl #(
    parameter int IQ_SIZE = 8
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic [1:0]                 push_cnt_i,
    input  logic                       pop_i,
    output logic [$clog2(IQ_SIZE)-1:0] head_o,
    output logic [$clog2(IQ_SIZE)-1:0] tail_o,
    output logic                       entry_ready_o
);

    localparam int PTR_W = $clog2(IQ_SIZE);
    localparam int CNT_W = PTR_W + 1;

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] free_q;
    logic [CNT_W-1:0] free_next;

    // at most one pop and two pushes per cycle
    assign free_next = free_q - CNT_W'(push_cnt_i) + CNT_W'(pop_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            free_q        <= CNT_W'(IQ_SIZE);
            entry_ready_o <= 1'b1;
        end else if (flush_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            free_q        <= CNT_W'(IQ_SIZE);
            entry_ready_o <= 1'b1;
        end else begin
            if (pop_i) begin
                head_q <= head_q + PTR_W'(1);
            end
            tail_q <= tail_q + PTR_W'(push_cnt_i);
            free_q <= free_next;
            // room for a full dual dispatch next cycle
            entry_ready_o <= (free_next >= CNT_W'(2));
        end
    end

    assign head_o = head_q;
    assign tail_o = tail_q;

endmodule

// File: iq_entry.sv
`timescale 1ns/1ps

module iq_entry #(
    parameter int CDB_COUNT = 2
) (
    input  logic                                      clk,
    input  logic                                      rst_n_i,
    input  logic                                      flush_i,
    input  logic                                      init_i,
    input  mdu_pkg::iq_req_t                          req_i,
    input  logic                                      clear_i,
    input  cpu_types_pkg::cdb_t [CDB_COUNT-1:0]       cdb_i,
    output logic                                      busy_o,
    output logic                                      ready_o,
    output mdu_pkg::iq_req_t                          req_o
);

    logic             busy_q;
    mdu_pkg::iq_req_t req_q;
    mdu_pkg::iq_req_t cur_req;
    mdu_pkg::iq_req_t nxt_req;

    // --------------------------------------------------
    // operand capture from the CDB
    // --------------------------------------------------
    // incoming op in the init cycle, else the held one
    assign cur_req = init_i ? req_i : req_q;

    always_comb begin
        nxt_req = cur_req;
        for (int k = 0; k < 2; k++) begin
            if (!cur_req.src[k].ready) begin
                for (int c = 0; c < CDB_COUNT; c++) begin
                    if (cdb_i[c].valid && (cdb_i[c].tag == cur_req.src[k].tag)) begin
                        nxt_req.src[k].ready = 1'b1;
                        nxt_req.src[k].value = cdb_i[c].data;
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // occupancy and payload
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
        end else if (init_i) begin
            busy_q <= 1'b1;
        end else if (clear_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (init_i || busy_q) begin
            req_q <= nxt_req;
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q && req_q.src[0].ready && req_q.src[1].ready;
    assign req_o   = req_q;

endmodule

// File: mdu_iq.sv
`timescale 1ns/1ps

module mdu_iq #(
    parameter int IQ_SIZE   = 8,
    parameter int CDB_COUNT = 2
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  mdu_pkg::iq_req_t [1:0]              dispatch_i,
    input  logic [1:0]                          dispatch_valid_i,
    output logic                                entry_ready_o,
    input  cpu_types_pkg::cdb_t [CDB_COUNT-1:0] cdb_i,
    output mdu_pkg::mdu_req_t                   issue_o,
    output logic                                issue_valid_o,
    input  logic                                unit_ready_i
);

    localparam int PTR_W = $clog2(IQ_SIZE);

    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       tail;
    logic [PTR_W-1:0]       tail_p1;
    logic [1:0]             disp_v;
    logic [1:0]             push_cnt;
    logic                   first_v;
    logic                   second_v;
    mdu_pkg::iq_req_t       first_req;

    logic [IQ_SIZE-1:0]     entry_init;
    logic [IQ_SIZE-1:0]     entry_clear;
    logic [IQ_SIZE-1:0]     entry_busy;
    logic [IQ_SIZE-1:0]     entry_ready;
    mdu_pkg::iq_req_t [IQ_SIZE-1:0] entry_req_in;
    mdu_pkg::iq_req_t [IQ_SIZE-1:0] entry_req_out;

    logic                   head_ready;
    mdu_pkg::iq_req_t       head_req;
    logic                   issue_adv;
    logic                   pop;
    logic                   issue_valid_q;
    mdu_pkg::mdu_req_t      issue_q;

    // --------------------------------------------------
    // dispatch steering
    // --------------------------------------------------
    // strobes count only while the queue has room
    assign disp_v   = dispatch_valid_i & {2{entry_ready_o}};
    assign push_cnt = 2'(disp_v[0]) + 2'(disp_v[1]);
    assign first_v  = |disp_v;
    assign second_v = &disp_v;
    assign tail_p1  = tail + PTR_W'(1);

    // a lone slot-1 dispatch takes the tail position
    assign first_req = disp_v[0] ? dispatch_i[0] : dispatch_i[1];

    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            entry_init[i] = (first_v && (PTR_W'(i) == tail)) ||
                            (second_v && (PTR_W'(i) == tail_p1));
            entry_req_in[i] = (second_v && (PTR_W'(i) == tail_p1)) ? dispatch_i[1]
                                                                    : first_req;
            entry_clear[i] = pop && (PTR_W'(i) == head);
        end
    end

    iq_ptr_ctrl #(
        .IQ_SIZE(IQ_SIZE)
    ) i_ptr_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .push_cnt_i   (push_cnt),
        .pop_i        (pop),
        .head_o       (head),
        .tail_o       (tail),
        .entry_ready_o(entry_ready_o)
    );

    // --------------------------------------------------
    // slot array
    // --------------------------------------------------
    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry #(
            .CDB_COUNT(CDB_COUNT)
        ) i_entry (
            .clk    (clk),
            .rst_n_i(rst_n_i),
            .flush_i(flush_i),
            .init_i (entry_init[i]),
            .req_i  (entry_req_in[i]),
            .clear_i(entry_clear[i]),
            .cdb_i  (cdb_i),
            .busy_o (entry_busy[i]),
            .ready_o(entry_ready[i]),
            .req_o  (entry_req_out[i])
        );
    end

    // --------------------------------------------------
    // in-order issue from the head
    // --------------------------------------------------
    assign head_ready = entry_busy[head] && entry_ready[head];
    assign head_req   = entry_req_out[head];
    assign issue_adv  = !issue_valid_q || unit_ready_i;
    assign pop        = issue_adv && head_ready;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_valid_q <= 1'b0;
        end else if (flush_i) begin
            issue_valid_q <= 1'b0;
        end else if (issue_adv) begin
            issue_valid_q <= head_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issue_q.op     <= head_req.op;
            issue_q.dst    <= head_req.dst;
            issue_q.src[0] <= head_req.src[0].value;
            issue_q.src[1] <= head_req.src[1].value;
        end
    end

    assign issue_o       = issue_q;
    assign issue_valid_o = issue_valid_q;

endmodule

// File: mdu_div_fsm.sv
`timescale 1ns/1ps

module mdu_div_fsm (
    input  logic clk,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic start_i,
    input  logic is_div_i,
    input  logic res_ready_i,
    output logic load_o,
    output logic step_o,
    output logic unit_ready_o,
    output logic res_valid_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MUL,
        S_DIV,
        S_DONE
    } state_e;

    state_e     state_q;
    state_e     state_d;
    logic [4:0] count_q;

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    // S_MUL is also the setup cycle of a divide
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    state_d = S_MUL;
                end
            end
            S_MUL: begin
                state_d = is_div_i ? S_DIV : S_DONE;
            end
            S_DIV: begin
                if (count_q == 5'd31) begin
                    state_d = S_DONE;
                end
            end
            default: begin
                // hold the result until the FIFO takes it
                if (res_ready_i) begin
                    state_d = start_i ? S_MUL : S_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            count_q <= '0;
        end else if (flush_i) begin
            state_q <= S_IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            // 32 divide steps, count wraps back to zero
            count_q <= (state_q == S_DIV) ? count_q + 5'd1 : 5'd0;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign load_o       = (state_q == S_MUL);
    assign step_o       = (state_q == S_DIV);
    assign res_valid_o  = (state_q == S_DONE);
    assign unit_ready_o = (state_q == S_IDLE) || ((state_q == S_DONE) && res_ready_i);

endmodule

// File: mdu_unit.sv
`timescale 1ns/1ps

module mdu_unit (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  mdu_pkg::mdu_req_t req_i,
    input  logic              req_valid_i,
    output logic              unit_ready_o,
    output mdu_pkg::mdu_res_t res_o,
    output logic              res_valid_o,
    input  logic              res_ready_i
);

    logic                   accept;
    logic                   is_div;
    logic                   load;
    logic                   step;

    mdu_pkg::mdu_op_e       op_q;
    cpu_types_pkg::rob_id_t tag_q;
    cpu_types_pkg::word_t   a_q;
    cpu_types_pkg::word_t   b_q;

    logic signed [63:0]     prod_q;
    cpu_types_pkg::word_t   rem_q;
    cpu_types_pkg::word_t   quo_q;
    logic [32:0]            shifted;
    logic [32:0]            diff;

    assign accept = req_valid_i && unit_ready_o;
    assign is_div = (op_q == mdu_pkg::MDU_DIVU) || (op_q == mdu_pkg::MDU_REMU);

    mdu_div_fsm i_fsm (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .start_i     (req_valid_i),
        .is_div_i    (is_div),
        .res_ready_i (res_ready_i),
        .load_o      (load),
        .step_o      (step),
        .unit_ready_o(unit_ready_o),
        .res_valid_o (res_valid_o)
    );

    // operand capture on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= req_i.op;
            tag_q <= req_i.dst;
            a_q   <= req_i.src[0];
            b_q   <= req_i.src[1];
        end
    end

    // --------------------------------------------------
    // restoring divide step
    // --------------------------------------------------
    // zero divisor never borrows, so quotient ends all ones
    assign shifted = {rem_q, quo_q[31]};
    assign diff    = shifted - {1'b0, b_q};

    always_ff @(posedge clk) begin
        if (load) begin
            prod_q <= 64'($signed(a_q)) * 64'($signed(b_q));
            rem_q  <= '0;
            quo_q  <= a_q;
        end else if (step) begin
            if (!diff[32]) begin
                rem_q <= diff[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= shifted[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // result word select
    always_comb begin
        res_o.tag = tag_q;
        case (op_q)
            mdu_pkg::MDU_MUL:  res_o.data = prod_q[31:0];
            mdu_pkg::MDU_MULH: res_o.data = prod_q[63:32];
            mdu_pkg::MDU_DIVU: res_o.data = quo_q;
            default:           res_o.data = rem_q;
        endcase
    end

endmodule

// File: mdu_top.sv
`timescale 1ns/1ps

module mdu_top #(
    parameter int IQ_SIZE   = 8,
    parameter int CDB_COUNT = 2
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  mdu_pkg::iq_req_t [1:0]              dispatch_i,
    input  logic [1:0]                          dispatch_valid_i,
    output logic                                entry_ready_o,
    input  cpu_types_pkg::cdb_t [CDB_COUNT-1:0] cdb_i,
    output mdu_pkg::mdu_res_t                   res_o,
    output logic                                res_valid_o,
    input  logic                                res_ready_i
);

    // issue path between queue and unit
    mdu_pkg::mdu_req_t issue;
    logic              issue_valid;
    logic              unit_ready;

    mdu_iq #(
        .IQ_SIZE  (IQ_SIZE),
        .CDB_COUNT(CDB_COUNT)
    ) i_iq (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .dispatch_i      (dispatch_i),
        .dispatch_valid_i(dispatch_valid_i),
        .entry_ready_o   (entry_ready_o),
        .cdb_i           (cdb_i),
        .issue_o         (issue),
        .issue_valid_o   (issue_valid),
        .unit_ready_i    (unit_ready)
    );

    mdu_unit i_unit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .req_i       (issue),
        .req_valid_i (issue_valid),
        .unit_ready_o(unit_ready),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i)
    );

endmodule

// File: tb_mdu_checker.sv
`timescale 1ns/1ps

module tb_mdu_checker (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  logic                         entry_ready_i,
    input  mdu_pkg::mdu_res_t            res_i,
    input  logic                         res_valid_i,
    input  logic                         res_ready_i,
    input  logic                         issue_valid_i,
    input  logic                         unit_ready_i,
    input  logic [1:0]                   exp_push_i,
    input  mdu_pkg::mdu_req_t [1:0]      exp_req_i,
    input  int                           test_id_i,
    input  logic                         test_end_i,
    output int                           err_cnt_o,
    output int                           pend_o
);

    mdu_pkg::mdu_req_t exp_q[$];
    int                acc_q[$];
    logic              rst_seen;
    logic              flush_seen;
    logic              res_valid_d;
    int                cyc;
    int                checked;
    int                test_errs;
    int                low_cycles;

    function automatic string test_name(input int id);
        case (id)
            1:       return "mul_ready";
            2:       return "mulh_div_rem";
            3:       return "cdb_wakeup";
            4:       return "back_pressure";
            5:       return "dispatch_slots";
            default: return "flush";
        endcase
    endfunction

    // expected word straight from the operation rules
    function automatic cpu_types_pkg::word_t model(input mdu_pkg::mdu_req_t r);
        logic signed [63:0] p;
        p = $signed({{32{r.src[0][31]}}, r.src[0]}) * $signed({{32{r.src[1][31]}}, r.src[1]});
        case (r.op)
            mdu_pkg::MDU_MUL:  return p[31:0];
            mdu_pkg::MDU_MULH: return p[63:32];
            mdu_pkg::MDU_DIVU: return (r.src[1] == 0) ? 32'hffff_ffff : r.src[0] / r.src[1];
            default:           return (r.src[1] == 0) ? r.src[0] : r.src[0] % r.src[1];
        endcase
    endfunction

    task automatic fail(input string msg);
        $display("%s", msg);
        err_cnt_o = err_cnt_o + 1;
        test_errs = test_errs + 1;
    endtask

    initial begin
        err_cnt_o   = 0;
        pend_o      = 0;
        rst_seen    = 1'b0;
        flush_seen  = 1'b0;
        res_valid_d = 1'b0;
        cyc         = 0;
        checked     = 0;
        test_errs   = 0;
        low_cycles  = 0;
    end

    // --------------------------------------------------
    // compare on every clock edge
    // --------------------------------------------------
    always @(posedge clk) begin
        mdu_pkg::mdu_req_t e;
        cpu_types_pkg::word_t w;
        int acc_cyc;
        int lat;
        if (!rst_n_i) begin
            exp_q.delete();
            acc_q.delete();
        end else if (flush_i) begin
            exp_q.delete();
            acc_q.delete();
        end else begin
            // state right after reset or flush
            if ((rst_seen || flush_seen) && (!entry_ready_i || res_valid_i)) begin
                fail($sformatf("%s: entry_ready_o not 1 or res_valid_o not 0 after reset or flush",
                               test_name(test_id_i)));
            end
            if (!entry_ready_i) begin
                low_cycles = low_cycles + 1;
            end
            // latency counted from the cycle the unit accepts
            if (res_valid_i && !res_valid_d) begin
                if (acc_q.size() == 0) begin
                    fail($sformatf("%s: result appeared with no operation accepted by the unit",
                                   test_name(test_id_i)));
                end else begin
                    acc_cyc = acc_q.pop_front();
                    if (exp_q.size() > 0) begin
                        lat = (exp_q[0].op inside {mdu_pkg::MDU_DIVU, mdu_pkg::MDU_REMU}) ? 34 : 2;
                        if ((cyc - acc_cyc) != lat) begin
                            fail($sformatf("[FAIL] %s latency expected %0d actual %0d",
                                           test_name(test_id_i), lat, cyc - acc_cyc));
                        end
                    end
                end
            end
            if (res_valid_i && res_ready_i) begin
                if (exp_q.size() == 0) begin
                    fail($sformatf("%s: result for tag %0d arrived with nothing outstanding",
                                   test_name(test_id_i), res_i.tag));
                end else begin
                    e = exp_q.pop_front();
                    w = model(e);
                    checked = checked + 1;
                    if ((res_i.tag != e.dst) || (res_i.data != w)) begin
                        fail($sformatf("[FAIL] %s expected tag %0d data %h actual tag %0d data %h",
                                       test_name(test_id_i), e.dst, w, res_i.tag, res_i.data));
                    end
                end
            end
            if (issue_valid_i && unit_ready_i) begin
                acc_q.push_back(cyc);
            end
            // program order is slot 0 then slot 1
            for (int s = 0; s < 2; s++) begin
                if (exp_push_i[s]) begin
                    exp_q.push_back(exp_req_i[s]);
                end
            end
            if (test_end_i) begin
                if ((test_id_i == 4) && (low_cycles == 0)) begin
                    fail("back_pressure: entry_ready_o never fell while the queue filled");
                end
                $display("test %s: %0d results checked, %0d errors",
                         test_name(test_id_i), checked, test_errs);
                checked    = 0;
                test_errs  = 0;
                low_cycles = 0;
            end
        end
        rst_seen    = !rst_n_i;
        flush_seen  = flush_i;
        res_valid_d = res_valid_i;
        cyc         = cyc + 1;
        pend_o      = exp_q.size();
    end

endmodule

// File: tb_mdu_top.sv
`timescale 1ns/1ps

module tb_mdu_top;

    localparam int TOTAL_OPS = 24 + 60 + 40 + 60 + 40 + 40;
    localparam int WD_CYCLES = TOTAL_OPS * 60 + 2000;

    logic                           clk;
    logic                           rst_n_i;
    logic                           flush_i;
    mdu_pkg::iq_req_t [1:0]         dispatch_i;
    logic [1:0]                     dispatch_valid_i;
    logic                           entry_ready_o;
    cpu_types_pkg::cdb_t [1:0]      cdb_i;
    mdu_pkg::mdu_res_t              res_o;
    logic                           res_valid_o;
    logic                           res_ready_i;

    logic [1:0]                     exp_push;
    mdu_pkg::mdu_req_t [1:0]        exp_req;
    int                             test_id;
    logic                           test_end;
    int                             err_cnt;
    int                             pend;

    logic [15:0]                    lfsr;
    logic [4:0]                     next_tag;
    logic [4:0]                     pend_tag[$];
    cpu_types_pkg::word_t           pend_val[$];
    int                             pend_dly[$];

    mdu_top #(.IQ_SIZE(8), .CDB_COUNT(2)) i_dut (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .dispatch_i(dispatch_i), .dispatch_valid_i(dispatch_valid_i),
        .entry_ready_o(entry_ready_o), .cdb_i(cdb_i), .res_o(res_o),
        .res_valid_o(res_valid_o), .res_ready_i(res_ready_i)
    );

    tb_mdu_checker i_chk (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(flush_i), .entry_ready_i(entry_ready_o),
        .res_i(res_o), .res_valid_i(res_valid_o), .res_ready_i(res_ready_i),
        .issue_valid_i(i_dut.issue_valid), .unit_ready_i(i_dut.unit_ready),
        .exp_push_i(exp_push), .exp_req_i(exp_req), .test_id_i(test_id),
        .test_end_i(test_end), .err_cnt_o(err_cnt), .pend_o(pend)
    );

    always #5 clk = ~clk;

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // one operand, either ready or waiting on a fresh tag
    task automatic make_operand(input int wait_lvl, input logic zero_ok,
                                output mdu_pkg::operand_t o, output cpu_types_pkg::word_t v);
        v = rnd(32);
        if (zero_ok && (rnd(3) == 0)) begin
            v = 0;
        end else if (zero_ok && (rnd(3) == 0)) begin
            v = rnd(4);
        end
        o.ready = 1'b1;
        o.tag   = '0;
        o.value = v;
        if (int'(rnd(4)) < wait_lvl) begin
            o.ready = 1'b0;
            o.tag   = next_tag;
            o.value = '0;
            pend_tag.push_back(next_tag);
            pend_val.push_back(v);
            pend_dly.push_back(int'(rnd(3)));
            next_tag = next_tag + 5'd1;
        end
    endtask

    task automatic make_op(input int op_mode, input int wait_lvl, input int s);
        mdu_pkg::mdu_op_e op;
        cpu_types_pkg::word_t a;
        cpu_types_pkg::word_t b;
        if (op_mode == 0) begin
            op = mdu_pkg::MDU_MUL;
        end else begin
            op = mdu_pkg::mdu_op_e'(rnd(2));
            if ((op_mode == 1) && (op == mdu_pkg::MDU_MUL)) begin
                op = mdu_pkg::MDU_MULH;
            end
        end
        dispatch_i[s].op  = op;
        dispatch_i[s].dst = cpu_types_pkg::rob_id_t'(rnd(5));
        make_operand(wait_lvl, 1'b0, dispatch_i[s].src[0], a);
        make_operand(wait_lvl, 1'b1, dispatch_i[s].src[1], b);
        dispatch_valid_i[s] = 1'b1;
        exp_push[s]         = 1'b1;
        exp_req[s].op       = op;
        exp_req[s].dst      = dispatch_i[s].dst;
        exp_req[s].src[0]   = a;
        exp_req[s].src[1]   = b;
    endtask

    // broadcast due tags, two CDB slots per cycle
    task automatic drive_cdb();
        int lane;
        int n;
        lane = 0;
        n    = pend_tag.size();
        cdb_i = '0;
        for (int i = 0; i < n; i++) begin
            if ((pend_dly[0] <= 0) && (lane < 2)) begin
                cdb_i[lane] = '{valid: 1'b1, tag: pend_tag[0], data: pend_val[0]};
                lane = lane + 1;
            end else begin
                pend_tag.push_back(pend_tag[0]);
                pend_val.push_back(pend_val[0]);
                pend_dly.push_back(pend_dly[0] - 1);
            end
            void'(pend_tag.pop_front());
            void'(pend_val.pop_front());
            void'(pend_dly.pop_front());
        end
    endtask

    // --------------------------------------------------
    // one test: dispatch n ops, then drain
    // --------------------------------------------------
    task automatic run_test(input int id, input int n, input int op_mode, input int wait_lvl,
                            input int stall, input int slot_mode, input int flush_after);
        int sent;
        int pat;
        logic flushed;
        logic alt;
        sent    = 0;
        flushed = 1'b0;
        alt     = 1'b0;
        test_id = id;
        while ((sent < n) || (pend_tag.size() > 0)) begin
            @(posedge clk);
            #1;
            flush_i          = 1'b0;
            dispatch_valid_i = '0;
            exp_push         = '0;
            res_ready_i      = (int'(rnd(4)) >= stall);
            if ((flush_after > 0) && (sent >= flush_after) && !flushed) begin
                flush_i     = 1'b1;
                res_ready_i = 1'b0;
                cdb_i       = '0;
                flushed     = 1'b1;
                pend_tag.delete();
                pend_val.delete();
                pend_dly.delete();
            end else begin
                if (entry_ready_o && (sent < n) && rnd(1)) begin
                    // 0 both, 1 slot 0, 2 slot 1
                    pat = (slot_mode == 1) ? (alt ? 2 : 0) : int'(rnd(2)) % 3;
                    alt = !alt;
                    if ((pat == 0) && (n - sent == 1)) begin
                        pat = 1;
                    end
                    if (pat != 2) begin
                        make_op(op_mode, wait_lvl, 0);
                    end
                    if (pat != 1) begin
                        make_op(op_mode, wait_lvl, 1);
                    end
                    sent = sent + ((pat == 0) ? 2 : 1);
                end
                drive_cdb();
            end
        end
        do begin
            @(posedge clk);
            #1;
            flush_i          = 1'b0;
            dispatch_valid_i = '0;
            exp_push         = '0;
            cdb_i            = '0;
            res_ready_i      = 1'b1;
        end while (pend != 0);
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        clk              = 1'b0;
        rst_n_i          = 1'b0;
        flush_i          = 1'b0;
        dispatch_i       = '0;
        dispatch_valid_i = '0;
        cdb_i            = '0;
        res_ready_i      = 1'b1;
        exp_push         = '0;
        exp_req          = '0;
        test_id          = 1;
        test_end         = 1'b0;
        lfsr             = 16'd24239;
        next_tag         = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        run_test(1, 24, 0, 0, 0, 0, 0);
        run_test(2, 60, 1, 0, 0, 0, 0);
        run_test(3, 40, 2, 10, 0, 0, 0);
        run_test(4, 60, 2, 4, 12, 0, 0);
        run_test(5, 40, 2, 4, 4, 1, 0);
        run_test(6, 40, 2, 4, 4, 0, 12);
        $display("tests 6, errors %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog sized from the op count
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: compile.f
cpu_types_pkg.sv
mdu_pkg.sv
iq_ptr_ctrl.sv
iq_entry.sv
mdu_iq.sv
mdu_div_fsm.sv
mdu_unit.sv
mdu_top.sv
tb_mdu_checker.sv
tb_mdu_top.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --timing -j 0
TOP        ?= tb_mdu_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
